/* bench/tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// Testbench clock, period 8, and reset generator
////////////////////////////////////////////////////////////

module tb_clock_gen (
	output logic clk_i,
	output logic rst,
	input  logic rst_req          // Extra reset from the test sequence
);
	logic por = 1'b1;

	initial
		clk_i = 1'b0;

	always
		#4 clk_i = ~clk_i;

	// Power-on reset over two rising edges
	initial begin
		repeat (2) @(posedge clk_i);
		#1 por = 1'b0;
	end

	assign rst = por || rst_req;

endmodule

/* bench/tb_lm32_trace_unit.sv */
////////////////////////////////////////////////////////////
// Table-driven testbench for the trace unit
// Pipeline model, expected record queue and word checks
////////////////////////////////////////////////////////////

module tb_lm32_trace_unit;
	import trace_pkg::*;

	typedef struct packed {
		logic [word_w-1:0]    insn;
		logic [pc_w_bits-1:0] pc;
		logic                 sx;
		logic                 sm;
		logic                 vw;
		logic                 kw;
		logic [1:0]           n;        // Words expected from this retire
		logic [word_w-1:0]    w0;
		logic [word_w-1:0]    w1;
		logic [word_w-1:0]    w2;
	} row_t;

	localparam logic [word_w-1:0] idle_insn = {6'h2d, 26'd0};

	logic                 clk_i, rst, rst_req;
	logic                 stall_x, stall_m, valid_w, kill_w;
	logic [word_w-1:0]    instruction_d;
	logic [pc_w_bits-1:0] pc_w;
	logic [word_w-1:0]    trace_word;
	logic                 trace_strobe, trace_last, overflow;

	row_t   tbl [$];
	row_t   exp_q [$];
	row_t   cur;
	insn_u  mx, mm, mw;                 // Model X, M and W registers
	integer seed = 32'ha1cb;
	int     widx, flood_start, cycles, quiet, dropped, mism_errs, other_errs;
	int     limit = 1000;
	logic   lossy = 1'b0;
	logic   ovf_seen = 1'b0;

	tb_clock_gen u_clk (.clk_i(clk_i), .rst(rst), .rst_req(rst_req));

	lm32_trace_unit UUT (.*);

	////////////////////////////////////////////////////////////
	// Instruction builders, register fields random

	function automatic insn_u imm_insn(logic [5:0] op, logic [15:0] imm);
		insn_u u;
		u.imm_f.opcode = op;
		u.imm_f.r3     = 5'($random(seed));
		u.imm_f.r2     = 5'($random(seed));
		u.imm_f.imm16  = imm;
		return u;
	endfunction

	function automatic insn_u reg_insn(logic [5:0] op);
		insn_u u;
		u          = imm_insn(op, 16'h0);
		u.reg_f.r1 = 5'($random(seed));
		return u;
	endfunction

	function automatic insn_u jmp_insn(logic [5:0] op, logic [25:0] imm);
		insn_u u;
		u.jmp_f.opcode = op;
		u.jmp_f.imm26  = imm;
		return u;
	endfunction

	// Byte target, pc plus the word offset
	function automatic logic [word_w-1:0] target_of(insn_u u, logic [pc_w_bits-1:0] pc);
		logic [word_w-1:0] off;
		if (u.jmp_f.opcode == op_bi || u.jmp_f.opcode == op_calli)
			off = {{6{u.jmp_f.imm26[25]}}, u.jmp_f.imm26};
		else
			off = {{16{u.imm_f.imm16[15]}}, u.imm_f.imm16};
		return {pc, 2'b00} + (off << 2);
	endfunction

	// One table row, expected record from the model W register
	task automatic add_row(insn_u insn, logic [pc_w_bits-1:0] pc, logic sx, logic sm,
			logic vw, logic kw);
		row_t r;
		r = '{insn, pc, sx, sm, vw, kw, 2'd0, 32'd0, 32'd0, 32'd0};
		if (vw && !kw) begin
			r.n  = 2'd2;
			r.w0 = {pc, 2'b00};
			r.w1 = mw;
			case (mw.reg_f.opcode)
				op_be, op_bg, op_bge, op_bgeu, op_bgu, op_bne, op_bi, op_calli: begin
					r.n  = 2'd3;
					r.w2 = target_of(mw, pc);
				end
				default: ;
			endcase
		end
		mw = mm;                          // W follows M every edge
		if (!sm)
			mm = mx;
		if (!sx)
			mx = insn;
		tbl.push_back(r);
	endtask

	// Same instruction for three cycles, retire on the last
	task automatic add_group(insn_u insn, logic [pc_w_bits-1:0] pc, logic vw, logic kw);
		add_row(insn, pc, 0, 0, 0, 0);
		add_row(insn, pc, 0, 0, 0, 0);
		add_row(insn, pc, 0, 0, vw, kw);
	endtask

	task automatic build_table;
		int i;
		mx = idle_insn;
		mm = idle_insn;
		mw = idle_insn;
		for (i = 0; i < 4; i++)
			add_row(idle_insn, 30'h0, 0, 0, 0, 0);
		add_group(reg_insn(6'h2d), 30'h100, 1, 0);
		add_group(imm_insn(6'h0d, 16'($random(seed))), 30'h101, 1, 0);
		add_group(imm_insn(op_be, 16'h0010), 30'h102, 1, 0);
		add_group(imm_insn(op_bne, 16'hfff0), 30'h103, 1, 0);   // Backward
		add_group(imm_insn(op_bg, 16'($random(seed))), 30'h104, 1, 0);
		add_group(imm_insn(op_bge, 16'h8000), 30'h105, 1, 0);
		add_group(imm_insn(op_bgeu, 16'($random(seed))), 30'h106, 1, 0);
		add_group(imm_insn(op_bgu, 16'h7fff), 30'h107, 1, 0);
		add_group(jmp_insn(op_bi, 26'h0000400), 30'h108, 1, 0);
		add_group(jmp_insn(op_bi, 26'h3ffffc0), 30'h109, 1, 0);
		add_group(jmp_insn(op_calli, 26'($random(seed))), 30'h10a, 1, 0);
		add_group(reg_insn(6'h2d), 30'h10b, 1, 0);
		// Killed, then not valid
		add_group(imm_insn(op_be, 16'h0004), 30'h110, 1, 1);
		add_group(reg_insn(6'h2d), 30'h111, 0, 0);
		add_group(reg_insn(6'h2d), 30'h112, 1, 0);
		// Held bgu retires twice under stall_m, then calli under stall_x
		add_group(imm_insn(op_bgu, 16'hffff), 30'h120, 0, 0);
		for (i = 0; i < 6; i++)
			add_row(reg_insn(6'h2d), 30'h121 + 30'(i), 0, 1, i % 3 == 2, 0);
		add_group(jmp_insn(op_calli, 26'h2000000), 30'h130, 1, 0);
		for (i = 0; i < 6; i++)
			add_row(reg_insn(6'h2e), 30'h131 + 30'(i), 1, 0, i % 3 == 2, 0);
		add_group(reg_insn(6'h2d), 30'h140, 1, 0);
		for (i = 0; i < 8; i++)
			add_row(idle_insn, 30'h0, 0, 0, 0, 0);
		flood_start = tbl.size();
		for (i = 0; i < 40; i++)          // Retire every cycle
			add_row(i % 2 ? reg_insn(6'h2d) : imm_insn(op_bne, 16'($random(seed))),
				30'h2000 + 30'(i), 0, 0, 1, 0);
		for (i = 0; i < 4; i++)
			add_row(idle_insn, 30'h0, 0, 0, 0, 0);
	endtask

	////////////////////////////////////////////////////////////
	// Output checks

	task automatic check_word;
		logic [word_w-1:0] exp_word;
		logic              exp_last;
		if (widx == 0) begin
			while (lossy && exp_q.size() > 0 && exp_q[0].w0 != trace_word) begin
				cur = exp_q.pop_front();  // Dropped on overflow
				dropped++;
			end
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("unexpected trace word %h with no record pending", trace_word);
				return;
			end
			cur = exp_q.pop_front();
		end
		exp_word = (widx == 0) ? cur.w0 : (widx == 1) ? cur.w1 : cur.w2;
		exp_last = (widx == cur.n - 1);
		if (trace_word !== exp_word) begin
			mism_errs++;
			$display("mismatch trace_word: got %h, expected %h", trace_word, exp_word);
		end
		if (trace_last !== exp_last) begin
			mism_errs++;
			$display("mismatch trace_last: got %h, expected %h", trace_last, exp_last);
		end
		widx = exp_last ? 0 : widx + 1;
	endtask

	always @(negedge clk_i) begin
		if (!rst && trace_strobe)
			check_word();
		if (rst)
			ovf_seen = 1'b0;
		else if (overflow)
			ovf_seen = 1'b1;
		else if (ovf_seen) begin
			other_errs++;
			$display("overflow went low again without a reset");
			ovf_seen = 1'b0;
		end
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the trace stream never went quiet", limit);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		int i;
		rst_req       = 1'b0;
		stall_x       = 1'b0;
		stall_m       = 1'b0;
		valid_w       = 1'b0;
		kill_w        = 1'b0;
		instruction_d = idle_insn;
		pc_w          = '0;
		build_table();
		limit = tbl.size() * 6 + 50;
		wait (rst == 1'b0);
		for (i = 0; i < tbl.size(); i++) begin
			@(posedge clk_i);
			#1;
			if (i == flood_start) begin
				if (exp_q.size() != 0 || widx != 0 || overflow) begin
					other_errs++;
					$display("records still pending or overflow set before the flood");
				end
				lossy = 1'b1;
			end
			instruction_d = tbl[i].insn;
			pc_w          = tbl[i].pc;
			stall_x       = tbl[i].sx;
			stall_m       = tbl[i].sm;
			valid_w       = tbl[i].vw;
			kill_w        = tbl[i].kw;
			if (tbl[i].n != 0)
				exp_q.push_back(tbl[i]);
		end
		quiet = 0;
		while (quiet < 4) begin
			@(negedge clk_i);
			quiet = trace_strobe ? 0 : quiet + 1;
		end
		dropped += exp_q.size();
		exp_q.delete();
		if (!overflow || dropped == 0) begin
			other_errs++;
			$display("the flood of retires did not set overflow or drop a record");
		end
		// Only a reset clears overflow
		@(posedge clk_i);
		#1 rst_req = 1'b1;
		repeat (2) @(posedge clk_i);
		#1 rst_req = 1'b0;
		lossy = 1'b0;
		widx  = 0;
		repeat (4) @(negedge clk_i);
		if (overflow !== 1'b0) begin
			other_errs++;
			$display("overflow still set after reset");
		end
		$display("errors: %0d mismatches, %0d other", mism_errs, other_errs);
		if (mism_errs == 0 && other_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* capture/trace_capture.sv */
////////////////////////////////////////////////////////////
// Pipeline follower for the X, M and W stages
// Retire detection and branch / jump target resolution
////////////////////////////////////////////////////////////

module trace_capture (
	input  logic                             clk_i,
	input  logic                             rst,
	input  logic                             stall_x,
	input  logic                             stall_m,
	input  logic                             valid_w,
	input  logic                             kill_w,
	input  logic [trace_pkg::word_w-1:0]     instruction_d,
	input  logic [trace_pkg::pc_w_bits-1:0]  pc_w,
	output trace_pkg::trace_rec_t            rec,
	output logic                             push
);
	import trace_pkg::*;

	insn_u                insn_x;
	insn_u                insn_m;
	insn_u                insn_w;
	logic [op_w-1:0]      opcode;
	logic                 is_branch;
	logic                 is_jump;
	logic [pc_w_bits-1:0] branch_off;
	logic [pc_w_bits-1:0] jump_off;
	logic [pc_w_bits-1:0] target_pc;
	logic                 retire;

	////////////////////////////////////////////////////////////
	// Instruction registers, held while the stage stalls

	always_ff @(posedge clk_i) begin
		if (!stall_x)
			insn_x <= instruction_d;
		if (!stall_m)
			insn_m <= insn_x;
		insn_w <= insn_m;             // W never stalls
	end

	////////////////////////////////////////////////////////////
	// Decode of the W word

	assign opcode = insn_w.reg_f.opcode;

	always_comb begin
		is_branch = 1'b0;
		is_jump   = 1'b0;
		case (opcode)
			op_be, op_bg, op_bge, op_bgeu, op_bgu, op_bne: is_branch = 1'b1;
			op_bi, op_calli:                               is_jump   = 1'b1;
			default: ;
		endcase
	end

	// Sign extension to word address width
	assign branch_off = {{(pc_w_bits-16){insn_w.imm_f.imm16[15]}}, insn_w.imm_f.imm16};
	assign jump_off   = {{(pc_w_bits-26){insn_w.jmp_f.imm26[25]}}, insn_w.jmp_f.imm26};
	assign target_pc  = pc_w + (is_jump ? jump_off : branch_off);

	assign retire = valid_w && !kill_w;

	// Record built from W as seen at the retire edge
	always_ff @(posedge clk_i) begin
		if (retire) begin
			rec.pc         <= pc_w;
			rec.insn       <= insn_w;
			rec.has_target <= is_branch || is_jump;
			rec.target     <= (is_branch || is_jump) ? {target_pc, 2'b00} : '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst)
			push <= 1'b0;
		else
			push <= retire;           // One cycle after retire
	end

	// A retired record is always fully known
	assert property (@(posedge clk_i) disable iff (rst) push |-> !$isunknown(rec))
		else $error("push with an unknown record");

endmodule

/* common/trace_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths and opcode constants for the trace unit
// Instruction word layouts and their union
// Trace record passed from capture through the FIFO
////////////////////////////////////////////////////////////

package trace_pkg;

	localparam int word_w     = 32;                  // Data word width
	localparam int pc_w_bits  = 30;                  // Word address width
	localparam int fifo_depth = 8;                   // Records held, power of two
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int op_w       = 6;

	////////////////////////////////////////////////////////////
	// Opcodes with a resolvable target

	localparam logic [op_w-1:0] op_be    = 6'h11;
	localparam logic [op_w-1:0] op_bg    = 6'h12;
	localparam logic [op_w-1:0] op_bge   = 6'h13;
	localparam logic [op_w-1:0] op_bgeu  = 6'h14;
	localparam logic [op_w-1:0] op_bgu   = 6'h15;
	localparam logic [op_w-1:0] op_bne   = 6'h17;
	localparam logic [op_w-1:0] op_bi    = 6'h38;
	localparam logic [op_w-1:0] op_calli = 6'h3e;

	////////////////////////////////////////////////////////////
	// Instruction layouts

	typedef struct packed {
		logic [op_w-1:0] opcode;
		logic [4:0]      r3;
		logic [4:0]      r2;
		logic [4:0]      r1;
		logic [10:0]     unused;
	} reg_form_t;

	typedef struct packed {
		logic [op_w-1:0] opcode;
		logic [4:0]      r3;
		logic [4:0]      r2;
		logic [15:0]     imm16;      // Branch offset in words
	} imm_form_t;

	typedef struct packed {
		logic [op_w-1:0] opcode;
		logic [25:0]     imm26;      // bi / calli offset in words
	} jump_form_t;

	// Same word, three decodings
	typedef union packed {
		reg_form_t  reg_f;
		imm_form_t  imm_f;
		jump_form_t jmp_f;
	} insn_u;

	typedef struct packed {
		logic [pc_w_bits-1:0] pc;          // Word address
		insn_u                insn;
		logic                 has_target;
		logic [word_w-1:0]    target;      // Byte address
	} trace_rec_t;

endpackage

/* hdl/lm32_trace_unit.sv */
////////////////////////////////////////////////////////////
// Trace unit top, capture into FIFO into serializer
////////////////////////////////////////////////////////////

module lm32_trace_unit (
	input  logic                             clk_i,
	input  logic                             rst,
	input  logic                             stall_x,
	input  logic                             stall_m,
	input  logic                             valid_w,
	input  logic                             kill_w,
	input  logic [trace_pkg::word_w-1:0]     instruction_d,
	input  logic [trace_pkg::pc_w_bits-1:0]  pc_w,
	output logic [trace_pkg::word_w-1:0]     trace_word,
	output logic                             trace_strobe,
	output logic                             trace_last,
	output logic                             overflow
);
	import trace_pkg::*;

	trace_rec_t rec;
	trace_rec_t head;
	logic       push;
	logic       pop;
	logic       empty;

	trace_capture u_capture (
		.clk_i         (clk_i),
		.rst           (rst),
		.stall_x       (stall_x),
		.stall_m       (stall_m),
		.valid_w       (valid_w),
		.kill_w        (kill_w),
		.instruction_d (instruction_d),
		.pc_w          (pc_w),
		.rec           (rec),
		.push          (push)
	);

	trace_fifo u_fifo (
		.clk_i    (clk_i),
		.rst      (rst),
		.push     (push),
		.rec      (rec),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	trace_serializer u_serializer (
		.clk_i        (clk_i),
		.rst          (rst),
		.head         (head),
		.empty        (empty),
		.pop          (pop),
		.trace_word   (trace_word),
		.trace_strobe (trace_strobe),
		.trace_last   (trace_last)
	);

endmodule

/* hdl/trace_fifo.sv */
////////////////////////////////////////////////////////////
// Synchronous record FIFO
// Drops on full and keeps a sticky overflow level
////////////////////////////////////////////////////////////

module trace_fifo (
	input  logic                  clk_i,
	input  logic                  rst,
	input  logic                  push,
	input  trace_pkg::trace_rec_t rec,
	input  logic                  pop,
	output trace_pkg::trace_rec_t head,
	output logic                  empty,
	output logic                  overflow
);
	import trace_pkg::*;

	trace_rec_t            mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0]   count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full  = (count == (fifo_ptr_w+1)'(fifo_depth));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr];

	// A pop frees the slot in the same cycle
	assign do_push = push && (!full || pop);
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= rec;
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk_i) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sticky until reset
	always_ff @(posedge clk_i) begin
		if (rst)
			overflow <= 1'b0;
		else if (push && !do_push)
			overflow <= 1'b1;
	end

	// Serializer must only pop a valid head
	assert property (@(posedge clk_i) disable iff (rst) pop |-> !empty)
		else $error("pop while FIFO empty");

endmodule

/* hdl/trace_serializer.sv */
////////////////////////////////////////////////////////////
// Record to word stream, 2 or 3 words per record
////////////////////////////////////////////////////////////

module trace_serializer (
	input  logic                          clk_i,
	input  logic                          rst,
	input  trace_pkg::trace_rec_t         head,
	input  logic                          empty,
	output logic                          pop,
	output logic [trace_pkg::word_w-1:0]  trace_word,
	output logic                          trace_strobe,
	output logic                          trace_last
);
	import trace_pkg::*;

	trace_rec_t rec_q;         // Record being sent
	logic       busy;          // More words pending
	logic [1:0] idx;           // Next word to send

	// Take a new record once nothing is left to send
	assign pop = !empty && !busy;

	////////////////////////////////////////////////////////////
	// Word sequencer

	always_ff @(posedge clk_i) begin
		if (rst) begin
			busy         <= 1'b0;
			idx          <= 2'd0;
			trace_strobe <= 1'b0;
			trace_last   <= 1'b0;
		end else if (pop) begin
			busy         <= 1'b1;
			idx          <= 2'd1;
			trace_strobe <= 1'b1;     // Word 0 goes out now
			trace_last   <= 1'b0;
		end else if (busy) begin
			trace_strobe <= 1'b1;
			if (idx == 2'd1 && rec_q.has_target) begin
				idx        <= 2'd2;
				trace_last <= 1'b0;
			end else begin
				busy       <= 1'b0;   // Final word
				idx        <= 2'd0;
				trace_last <= 1'b1;
			end
		end else begin
			trace_strobe <= 1'b0;
			trace_last   <= 1'b0;
		end
	end

	// Payload path, no reset needed
	always_ff @(posedge clk_i) begin
		if (pop) begin
			rec_q      <= head;
			trace_word <= {head.pc, 2'b00};   // Byte pc
		end else if (busy) begin
			if (idx == 2'd1)
				trace_word <= rec_q.insn;
			else
				trace_word <= rec_q.target;
		end
	end

	// Words of one record go out back to back
	assert property (@(posedge clk_i) disable iff (rst)
			trace_strobe && !trace_last |=> trace_strobe)
		else $error("record words not back to back");

endmodule

/* lm32_trace_unit.f */
common/trace_pkg.sv
capture/trace_capture.sv
hdl/trace_fifo.sv
hdl/trace_serializer.sv
hdl/lm32_trace_unit.sv
bench/tb_clock_gen.sv
bench/tb_lm32_trace_unit.sv
